//--- compile.f
w_buffer_pkg.sv
w_buffer_clk_gate.sv
w_buffer_scm.sv
w_buffer_wb_regs.sv
w_buffer_feeder.sv
w_buffer_top.sv
tb_clk_gen.sv
w_buffer_asserts.sv
tb_w_buffer.sv

//--- Bender.yml
package:
  name: w_buffer

sources:
  - w_buffer_pkg.sv
  - w_buffer_clk_gate.sv
  - w_buffer_scm.sv
  - w_buffer_wb_regs.sv
  - w_buffer_feeder.sv
  - w_buffer_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - w_buffer_asserts.sv
      - tb_w_buffer.sv

//--- tb_w_buffer.sv
// single bus master, one access at a time; buffer rows hold no defined data before test 2.
`timescale 1ns/1ps

module tb_w_buffer;
  import w_buffer_pkg::*;

  localparam int ACK_LIMIT     = 32;
  localparam int FEED_LIMIT    = 4 * STAGE_WORDS;
  localparam int ACCESS_CYCLES = 2;
  localparam int FEED_CYCLES   = STAGE_WORDS + 2;
  // bus accesses per test are 16, 38, 9, 3 and 15; seven feeds in all.
  localparam int TEST_CYCLES   = 8 + 81 * ACCESS_CYCLES + 7 * FEED_CYCLES;

  logic                 clk;
  logic                 rst_n;
  logic                 wb_cyc;
  logic                 wb_stb;
  logic                 wb_we;
  logic [WB_AW-1:0]     wb_adr;
  logic [WORD_SIZE-1:0] wb_dat;
  logic [WORD_SIZE-1:0] wb_rdat;
  logic                 wb_ack;
  w_feed_t              feed;

  logic [WORD_SIZE-1:0] model [ROWS][COLS][ELMS];  // expected buffer contents.
  logic [WORD_SIZE-1:0] staged [STAGE_WORDS];
  int                   seed = 32'ha86f_e771;
  int                   cycle = 0;
  int                   feed_rot = 0;
  int                   feeds_done = 0;
  int                   last_feed_beats = 0;
  int                   last_cycle = 0;
  int                   ack_cycle = 0;
  int                   err_count = 0;
  int                   assert_fails = 0;
  int                   tests_failed = 0;
  int                   test_num = 0;
  int                   test_errs = 0;
  string                test_name;

  tb_clk_gen i_clk_gen (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  w_buffer_top DUT (
    .clk_i    ( clk     ),
    .rst_ni   ( rst_n   ),
    .wb_cyc_i ( wb_cyc  ),
    .wb_stb_i ( wb_stb  ),
    .wb_we_i  ( wb_we   ),
    .wb_adr_i ( wb_adr  ),
    .wb_dat_i ( wb_dat  ),
    .wb_dat_o ( wb_rdat ),
    .wb_ack_o ( wb_ack  ),
    .feed_o   ( feed    )
  );

  always @(posedge clk) cycle <= cycle + 1;

  // lane r reads row (r+rot) mod ROWS, column (beat mod COLS - r) mod COLS.
  function automatic logic [ROWS-1:0][WORD_SIZE-1:0] expected_beat(input int rot, input int beat);
    logic [ROWS-1:0][WORD_SIZE-1:0] lanes;
    int row;
    int col;
    for (int r = 0; r < ROWS; r++) begin
      row = (r + rot) % ROWS;
      col = (beat % COLS - r + COLS) % COLS;
      lanes[r] = model[row][col][beat / COLS];
    end
    return lanes;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus and sequence tasks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic bus_cycle(input logic we, input logic [WB_AW-1:0] adr,
                           input logic [WORD_SIZE-1:0] wdat, output logic [WORD_SIZE-1:0] rdat);
    int   waited;
    logic got_ack;
    waited  = 0;
    got_ack = 1'b0;
    // caller is on a falling edge, so back-to-back accesses meet the ack cycle.
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = we;
    wb_adr = adr;
    wb_dat = wdat;
    while (!got_ack && waited < ACK_LIMIT) begin
      @(negedge clk);  // ack is registered, stable here.
      waited++;
      got_ack = wb_ack;
    end
    rdat      = wb_rdat;
    ack_cycle = cycle;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    assert (got_ack) else begin
      $display("bus access to address %0d got no ack within %0d cycles", adr, ACK_LIMIT);
      err_count++;
    end
  endtask

  task automatic write_reg(input logic [WB_AW-1:0] adr, input logic [WORD_SIZE-1:0] data);
    logic [WORD_SIZE-1:0] unused;
    bus_cycle(1'b1, adr, data, unused);
  endtask

  task automatic read_reg(input logic [WB_AW-1:0] adr, output logic [WORD_SIZE-1:0] data);
    bus_cycle(1'b0, adr, '0, data);
  endtask

  task automatic check_value(input string what, input logic [WORD_SIZE-1:0] got,
                             input logic [WORD_SIZE-1:0] exp);
    assert (got === exp) else begin
      $display("[ERROR] %t: %s read %h, expected %h", $time, what, got, exp);
      err_count++;
    end
  endtask

  task automatic stage_random_row();
    for (int i = 0; i < STAGE_WORDS; i++) begin
      staged[i] = WORD_SIZE'($random(seed));
      write_reg(WB_AW'(i), staged[i]);
    end
  endtask

  task automatic commit_row(input int row);
    write_reg(REG_COMMIT, WORD_SIZE'(row));
    for (int c = 0; c < COLS; c++) begin
      for (int e = 0; e < ELMS; e++) begin
        model[row][c][e] = staged[c * ELMS + e];
      end
    end
  endtask

  task automatic start_feed(input int rot, output int target);
    write_reg(REG_ROT, WORD_SIZE'(rot));
    feed_rot = rot;
    target   = feeds_done + 1;
    write_reg(REG_FEED, '0);
  endtask

  task automatic await_feed(input int target);
    int waited;
    waited = 0;
    while (feeds_done < target && waited < FEED_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    assert (feeds_done >= target) else begin
      $display("feed did not end with a last beat within %0d cycles", FEED_LIMIT);
      err_count++;
    end
    assert (last_feed_beats == STAGE_WORDS) else begin
      $display("[ERROR] %t: feed gave %0d beats, expected %0d", $time, last_feed_beats,
               STAGE_WORDS);
      err_count++;
    end
  endtask

  task automatic begin_test(input string name);
    test_num++;
    test_name = name;
    test_errs = err_count;
  endtask

  task automatic end_test();
    err_count    += DUT.i_asserts.fail_count - assert_fails;  // protocol failures.
    assert_fails  = DUT.i_asserts.fail_count;
    if (err_count == test_errs) begin
      $display("test %0d %s: pass", test_num, test_name);
    end else begin
      $display("test %0d %s: FAIL, %0d failed checks", test_num, test_name, err_count - test_errs);
      tests_failed++;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // feed checker
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin : compare
    logic [ROWS-1:0][WORD_SIZE-1:0] exp;
    int beat;
    beat = 0;
    forever begin
      @(negedge clk);
      if (rst_n && feed.valid) begin
        exp = expected_beat(feed_rot, beat);
        assert (feed.data === exp) else begin
          $display("[ERROR] %t: beat %0d rot %0d lanes %h, expected %h", $time, beat,
                   feed_rot, feed.data, exp);
          err_count++;
        end
        assert (feed.last === (beat == STAGE_WORDS - 1)) else begin
          $display("[ERROR] %t: last is %b on beat %0d", $time, feed.last, beat);
          err_count++;
        end
        beat++;
        if (feed.last) begin
          last_feed_beats = beat;
          last_cycle      = cycle;
          feeds_done++;
          beat = 0;
        end
      end
    end
  end

  initial begin : watchdog
    repeat (4 * TEST_CYCLES) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles", 4 * TEST_CYCLES);
    $display("Errors found");
    $finish;
  end

  initial begin : main
    logic [WORD_SIZE-1:0] rd;
    int target;
    $timeformat(-9, 0, " ns", 0);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    wb_adr = '0;
    wb_dat = '0;
    wait (rst_n === 1'b1);

    begin_test("staging read-back");
    stage_random_row();
    for (int i = 0; i < STAGE_WORDS; i++) begin
      read_reg(WB_AW'(i), rd);
      check_value("staging word", rd, staged[i]);
    end
    end_test();

    begin_test("fill and feed");
    for (int row = 0; row < ROWS; row++) begin
      stage_random_row();
      commit_row(row);
    end
    start_feed(0, target);
    await_feed(target);
    end_test();

    begin_test("rotation");
    for (int rot = 1; rot < ROWS; rot++) begin
      start_feed(rot, target);
      read_reg(REG_ROT, rd);
      check_value("rot register", rd, WORD_SIZE'(rot));
      await_feed(target);
    end
    end_test();

    begin_test("clear");
    write_reg(REG_CLEAR, '0);
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        for (int e = 0; e < ELMS; e++) begin
          model[r][c][e] = '0;
        end
      end
    end
    start_feed(1, target);
    await_feed(target);
    end_test();

    begin_test("busy stall");
    stage_random_row();
    start_feed(2, target);
    read_reg(REG_FEED, rd);
    check_value("busy during feed", rd, 16'd1);
    commit_row(1);  // stalls until the running feed is done.
    assert (feeds_done >= target && ack_cycle > last_cycle) else begin
      $display("commit was acked at cycle %0d before the running feed ended", ack_cycle);
      err_count++;
    end
    read_reg(REG_FEED, rd);
    check_value("busy after feed", rd, 16'd0);
    start_feed(2, target);
    await_feed(target);
    end_test();

    $display("summary: %0d tests, %0d failed, %0d failed checks", test_num, tests_failed,
             err_count);
    if (err_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- w_buffer_asserts.sv
// covers bus handshake and feed flag timing only; lane data is checked by the testbench.
`timescale 1ns/1ps

module w_buffer_asserts (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic                  cyc_i,
  input logic                  stb_i,
  input logic                  ack_i,
  input logic                  busy_i,
  input w_buffer_pkg::w_feed_t feed_i
);

  int fail_count = 0;  // failed assertions so far.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // wishbone handshake
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  ack_after_req : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_i |-> $past(cyc_i && stb_i))
    else begin
      $error("ack without a request in the cycle before");
      fail_count++;
    end

  ack_single : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_i |=> !ack_i)
    else begin
      $error("ack held for two cycles");
      fail_count++;
    end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // feed flags
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  valid_after_busy : assert property (@(posedge clk_i) disable iff (!rst_ni)
    feed_i.valid |-> $past(busy_i))
    else begin
      $error("feed valid without busy in the cycle before");
      fail_count++;
    end

  last_with_valid : assert property (@(posedge clk_i) disable iff (!rst_ni)
    feed_i.last |-> feed_i.valid)
    else begin
      $error("feed last without valid");
      fail_count++;
    end

endmodule

bind w_buffer_top w_buffer_asserts i_asserts (
  .clk_i  ( clk_i    ),
  .rst_ni ( rst_ni   ),
  .cyc_i  ( wb_cyc_i ),
  .stb_i  ( wb_stb_i ),
  .ack_i  ( wb_ack_o ),
  .busy_i ( busy     ),
  .feed_i ( feed_o   )
);

//--- tb_clk_gen.sv
// free-running 40 ns clock from time zero; reset is released on a falling edge after 8 cycles.
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam int HALF_PERIOD_NS = 20;
  localparam int RESET_CYCLES   = 8;

  initial begin : clock
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

  initial begin : reset
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;  // released mid-cycle.
  end

endmodule

//--- w_buffer_top.sv
// no feed back-pressure; feed_o.data is only meaningful while feed_o.valid is high.
`timescale 1ns/1ps

module w_buffer_top (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               wb_cyc_i,
  input  logic                               wb_stb_i,
  input  logic                               wb_we_i,
  input  logic [w_buffer_pkg::WB_AW-1:0]     wb_adr_i,
  input  logic [w_buffer_pkg::WORD_SIZE-1:0] wb_dat_i,
  output logic [w_buffer_pkg::WORD_SIZE-1:0] wb_dat_o,
  output logic                               wb_ack_o,
  output wire  w_buffer_pkg::w_feed_t        feed_o
);
  import w_buffer_pkg::*;

  w_row_t            wdata;
  w_rd_t             rd;
  logic              write_en;
  logic [ROW_AW-1:0] write_addr;
  logic              clear;
  logic [ROW_AW-1:0] rot;
  logic              feed_start;
  logic              busy;

  w_buffer_wb_regs i_regs (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .wb_cyc_i     ( wb_cyc_i   ),
    .wb_stb_i     ( wb_stb_i   ),
    .wb_we_i      ( wb_we_i    ),
    .wb_adr_i     ( wb_adr_i   ),
    .wb_dat_i     ( wb_dat_i   ),
    .wb_dat_o     ( wb_dat_o   ),
    .wb_ack_o     ( wb_ack_o   ),
    .busy_i       ( busy       ),
    .wdata_o      ( wdata      ),
    .write_en_o   ( write_en   ),
    .write_addr_o ( write_addr ),
    .clear_o      ( clear      ),
    .rot_o        ( rot        ),
    .feed_start_o ( feed_start )
  );

  // flags and lane data meet in feed_o.
  w_buffer_feeder i_feeder (
    .clk_i   ( clk_i        ),
    .rst_ni  ( rst_ni       ),
    .start_i ( feed_start   ),
    .rot_i   ( rot          ),
    .rd_o    ( rd           ),
    .busy_o  ( busy         ),
    .valid_o ( feed_o.valid ),
    .last_o  ( feed_o.last  )
  );

  w_buffer_scm i_scm (
    .clk_i        ( clk_i       ),
    .rst_ni       ( rst_ni      ),
    .clear_i      ( clear       ),
    .write_en_i   ( write_en    ),
    .write_addr_i ( write_addr  ),
    .wdata_i      ( wdata       ),
    .rd_i         ( rd          ),
    .rdata_o      ( feed_o.data )
  );

endmodule

//--- w_buffer_feeder.sv
// eight beats per feed, no stall; rot is sampled at start and held for the whole feed.
`timescale 1ns/1ps

module w_buffer_feeder (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            start_i,
  input  logic [w_buffer_pkg::ROW_AW-1:0] rot_i,
  output w_buffer_pkg::w_rd_t             rd_o,
  output logic                            busy_o,
  output logic                            valid_o,
  output logic                            last_o
);
  import w_buffer_pkg::*;

  feed_state_e         state_q;
  logic [STAGE_AW-1:0] beat_q;
  logic [ROW_AW-1:0]   rot_q;
  logic                run;
  logic                final_beat;

  assign run        = (state_q == FEED_RUN);
  assign final_beat = (beat_q == STAGE_AW'(STAGE_WORDS - 1));
  assign busy_o     = run;

  always_ff @(posedge clk_i or negedge rst_ni) begin : fsm
    if (!rst_ni) begin
      state_q <= FEED_IDLE;
      beat_q  <= '0;
      rot_q   <= '0;
      valid_o <= 1'b0;
      last_o  <= 1'b0;
    end else begin
      valid_o <= run;                // data shows up one cycle after the read.
      last_o  <= run & final_beat;
      unique case (state_q)
        FEED_IDLE: begin
          if (start_i) begin
            state_q <= FEED_RUN;
            beat_q  <= '0;
            rot_q   <= rot_i;
          end
        end
        FEED_RUN: begin
          beat_q <= beat_q + 1'b1;
          if (final_beat) state_q <= FEED_IDLE;
        end
        default: state_q <= FEED_IDLE;
      endcase
    end
  end

  always_comb begin : read_cmd
    rd_o.read_en   = run;
    rd_o.elm       = beat_q[COL_AW +: ELM_AW];  // beat / COLS.
    rd_o.cols_offs = beat_q[COL_AW-1:0];        // beat mod COLS.
    for (int r = 0; r < ROWS; r++) begin
      rd_o.rows_addr[r] = rot_q + ROW_AW'(r);  // wraps mod ROWS.
    end
  end

endmodule

//--- w_buffer_wb_regs.sv
// wishbone classic slave, one wait state per access; command writes stall while the feeder is busy.
`timescale 1ns/1ps

module w_buffer_wb_regs (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   wb_cyc_i,
  input  logic                                   wb_stb_i,
  input  logic                                   wb_we_i,
  input  logic [w_buffer_pkg::WB_AW-1:0]         wb_adr_i,
  input  logic [w_buffer_pkg::WORD_SIZE-1:0]     wb_dat_i,
  output logic [w_buffer_pkg::WORD_SIZE-1:0]     wb_dat_o,
  output logic                                   wb_ack_o,
  input  logic                                   busy_i,
  output w_buffer_pkg::w_row_t                   wdata_o,
  output logic                                   write_en_o,
  output logic [w_buffer_pkg::ROW_AW-1:0]        write_addr_o,
  output logic                                   clear_o,
  output logic [w_buffer_pkg::ROW_AW-1:0]        rot_o,
  output logic                                   feed_start_o
);
  import w_buffer_pkg::*;

  w_reg_e                                adr;
  logic                                  req;
  logic                                  is_cmd;
  logic                                  stall;
  logic                                  accept;
  logic                                  wr;
  logic [WORD_SIZE-1:0]                  rdata_d;
  logic [STAGE_WORDS-1:0][WORD_SIZE-1:0] stage_q;

  assign adr = w_reg_e'(wb_adr_i);  // 12..15 fall through as unmapped.

  // no new request in the ack cycle.
  assign req    = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign is_cmd = adr inside {REG_COMMIT, REG_CLEAR, REG_FEED};
  assign stall  = wb_we_i & is_cmd & busy_i;  // held off until busy drops.
  assign accept = req & ~stall;
  assign wr     = accept & wb_we_i;

  // staging layout matches w_row_t word order.
  assign wdata_o = stage_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read mux
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin : read_mux
    rdata_d = '0;
    if (adr inside {[REG_STAGE_0:REG_STAGE_7]}) begin
      rdata_d = stage_q[wb_adr_i[STAGE_AW-1:0]];
    end else if (adr == REG_ROT) begin
      rdata_d = WORD_SIZE'(rot_o);
    end else if (adr == REG_FEED) begin
      rdata_d = WORD_SIZE'(busy_i);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // ack and command pulses
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk_i or negedge rst_ni) begin : handshake
    if (!rst_ni) begin
      wb_ack_o     <= 1'b0;
      write_en_o   <= 1'b0;
      clear_o      <= 1'b0;
      feed_start_o <= 1'b0;
      write_addr_o <= '0;
      rot_o        <= '0;
    end else begin
      wb_ack_o     <= accept;
      write_en_o   <= wr & (adr == REG_COMMIT);  // all pulses line up with ack.
      clear_o      <= wr & (adr == REG_CLEAR);
      feed_start_o <= wr & (adr == REG_FEED);
      if (wr && adr == REG_COMMIT) begin
        write_addr_o <= wb_dat_i[ROW_AW-1:0];
      end
      if (wr && adr == REG_ROT) begin
        rot_o <= wb_dat_i[ROW_AW-1:0];
      end
    end
  end

  // payload only.
  always_ff @(posedge clk_i) begin : data_regs
    if (wr && adr inside {[REG_STAGE_0:REG_STAGE_7]}) begin
      stage_q[wb_adr_i[STAGE_AW-1:0]] <= wb_dat_i;
    end
    if (accept) begin
      wb_dat_o <= rdata_d;
    end
  end

endmodule

//--- w_buffer_scm.sv
// latch rows hold no reset, so contents stay undefined until a clear; reads lag one cycle.
`timescale 1ns/1ps

module w_buffer_scm (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  input  logic                                              clear_i,
  input  logic                                              write_en_i,
  input  logic [w_buffer_pkg::ROW_AW-1:0]                   write_addr_i,
  input  w_buffer_pkg::w_row_t                              wdata_i,
  input  w_buffer_pkg::w_rd_t                               rd_i,
  output logic [w_buffer_pkg::ROWS-1:0][w_buffer_pkg::WORD_SIZE-1:0] rdata_o
);
  import w_buffer_pkg::*;

  w_row_t                      buffer_q [ROWS];
  w_row_t                      wdata_q;

  logic [ELM_AW-1:0]           elm_q;
  logic [COL_AW-1:0]           cols_offs_q;
  logic [ROWS-1:0][ROW_AW-1:0] rows_addr_q;
  logic [ROWS-1:0][COL_AW-1:0] cols_addr;

  logic [ROWS-1:0]             row_en;
  logic [ROWS-1:0]             clk_w;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk_i or negedge rst_ni) begin : sample_raddr
    if (!rst_ni) begin
      elm_q       <= '0;
      cols_offs_q <= '0;
      rows_addr_q <= '0;
    end else if (clear_i) begin
      elm_q       <= '0;
      cols_offs_q <= '0;
      rows_addr_q <= '0;
    end else if (rd_i.read_en) begin
      elm_q       <= rd_i.elm;
      cols_offs_q <= rd_i.cols_offs;
      rows_addr_q <= rd_i.rows_addr;
    end
  end

  for (genvar r = 0; r < ROWS; r++) begin : gen_lanes
    // lane r lags lane 0 by r columns, wraps mod COLS.
    assign cols_addr[r] = cols_offs_q - COL_AW'(r);
    assign rdata_o[r]   = buffer_q[rows_addr_q[r]][cols_addr[r]][elm_q];
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // write side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk_i or negedge rst_ni) begin : sample_wdata
    if (!rst_ni) begin
      wdata_q <= '0;
    end else if (clear_i) begin
      wdata_q <= '0;  // latches pick up zeros on the next high phase.
    end else if (write_en_i) begin
      wdata_q <= wdata_i;
    end
  end

  for (genvar r = 0; r < ROWS; r++) begin : gen_rows
    assign row_en[r] = (write_en_i && write_addr_i == ROW_AW'(r)) || clear_i;

    w_buffer_clk_gate i_row_cg (
      .clk_i ( clk_i     ),
      .en_i  ( row_en[r] ),
      .clk_o ( clk_w[r]  )
    );

    // transparent during the gated high phase.
    always_latch begin : row_latch
      if (clk_w[r]) begin
        buffer_q[r] <= wdata_q;
      end
    end
  end

endmodule

//--- w_buffer_clk_gate.sv
// behavioural model for simulation; swap in a library ICG cell for synthesis, no test enable.
`timescale 1ns/1ps

module w_buffer_clk_gate (
  input  logic clk_i,
  input  logic en_i,
  output logic clk_o
);

  logic en_latched;

  // enable passes only while the clock is low,
  // so it is stable for the whole high phase.
  always_latch begin : en_latch
    if (!clk_i) begin
      en_latched <= en_i;
    end
  end

  assign clk_o = clk_i & en_latched;  // pulse in the high phase after en.

endmodule

//--- w_buffer_pkg.sv
// fixed geometry of 4x4x2 16-bit words; the skew wrap is only valid while COLS equals ROWS.
package w_buffer_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // buffer geometry
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int unsigned ROWS      = 4;
  localparam int unsigned COLS      = 4;
  localparam int unsigned ELMS      = 2;
  localparam int unsigned WORD_SIZE = 16;

  localparam int unsigned ROW_AW = $clog2(ROWS);
  localparam int unsigned COL_AW = $clog2(COLS);
  localparam int unsigned ELM_AW = $clog2(ELMS);

  localparam int unsigned STAGE_WORDS = COLS * ELMS;  // words per staged row.
  localparam int unsigned STAGE_AW    = $clog2(STAGE_WORDS);

  localparam int unsigned WB_AW = 4;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // register map and states
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // staged word for column c, element e sits at c*ELMS+e.
  typedef enum logic [WB_AW-1:0] {
    REG_STAGE_0 = 4'd0,
    REG_STAGE_1 = 4'd1,
    REG_STAGE_2 = 4'd2,
    REG_STAGE_3 = 4'd3,
    REG_STAGE_4 = 4'd4,
    REG_STAGE_5 = 4'd5,
    REG_STAGE_6 = 4'd6,
    REG_STAGE_7 = 4'd7,
    REG_COMMIT  = 4'd8,   // data selects the target row.
    REG_CLEAR   = 4'd9,
    REG_ROT     = 4'd10,
    REG_FEED    = 4'd11   // read gives busy in bit 0.
  } w_reg_e;

  typedef enum logic {
    FEED_IDLE,
    FEED_RUN
  } feed_state_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // datapath types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef logic [COLS-1:0][ELMS-1:0][WORD_SIZE-1:0] w_row_t;

  typedef struct packed {
    logic                           valid;
    logic                           last;
    logic [ROWS-1:0][WORD_SIZE-1:0] data;  // one word per lane.
  } w_feed_t;

  typedef struct packed {
    logic                        read_en;
    logic [ELM_AW-1:0]           elm;
    logic [COL_AW-1:0]           cols_offs;  // column of lane 0.
    logic [ROWS-1:0][ROW_AW-1:0] rows_addr;
  } w_rd_t;

endpackage
